/* rtl/wiscPkg.sv */
// Core package with widths, opcodes, instruction formats and pipeline stage records
package wiscPkg;

   // Word, register file and memory sizes
   localparam int dataWidth = 16;
   localparam int regAddrWidth = 3;
   localparam int imemDepth = 256;
   localparam int dmemDepth = 256;
   localparam int imemAddrWidth = $clog2(imemDepth);
   localparam int dmemAddrWidth = $clog2(dmemDepth);
   localparam logic [dataWidth-1:0] resetPc = '0;

   // Major opcodes, any other code is illegal
   typedef enum logic [4:0] {
      NOP   = 5'b00001,
      HALT  = 5'b00000,
      ADDI  = 5'b01000,
      LBI   = 5'b11000,
      LD    = 5'b10001,
      ST    = 5'b10000,
      RTYPE = 5'b11011,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      J     = 5'b00100
   } opcode_t;

   // RTYPE function field
   typedef enum logic [1:0] {
      ADD = 2'b00,
      SUB = 2'b01,
      AND = 2'b10,
      XOR = 2'b11
   } aluFunc_t;

   // Register format, rd = rs op rt
   typedef struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rt;
      logic [regAddrWidth-1:0] rd;
      aluFunc_t                func;
   } rFormat_t;

   // Immediate format for ADDI, LD and ST
   // ST takes its store data from rd
   typedef struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rs;
      logic [regAddrWidth-1:0] rd;
      logic [4:0]              imm;
   } iFormat_t;

   // Byte immediate format for LBI, BEQZ and BNEZ
   // J reads rs and imm together as an 11-bit offset
   typedef struct packed {
      opcode_t                 opcode;
      logic [regAddrWidth-1:0] rs;
      logic [7:0]              imm;
   } bFormat_t;

   typedef union packed {
      rFormat_t rFmt;
      iFormat_t iFmt;
      bFormat_t bFmt;
   } instrWord_t;

   // Fetch to decode
   typedef struct packed {
      logic                 valid;
      logic [dataWidth-1:0] pc;
      instrWord_t           instr;
   } fetchToDecode_t;

   // Decode to execute, imm is already sign-extended
   typedef struct packed {
      logic                    valid;
      opcode_t                 op;
      aluFunc_t                func;
      logic [dataWidth-1:0]    rsData;
      logic [dataWidth-1:0]    rtData;
      logic [dataWidth-1:0]    imm;
      logic [dataWidth-1:0]    pc;
      logic [regAddrWidth-1:0] dest;
      logic                    writesReg;
   } decodeToExec_t;

   // Execute to memory
   typedef struct packed {
      logic                    valid;
      logic [dataWidth-1:0]    result;
      logic [dataWidth-1:0]    storeData;
      logic                    memRead;
      logic                    memWrite;
      logic [regAddrWidth-1:0] dest;
      logic                    writesReg;
      logic                    halt;
   } execToMem_t;

   // Taken branch or jump
   typedef struct packed {
      logic                 taken;
      logic [dataWidth-1:0] target;
   } redirect_t;

   // Register write, also the retire trace
   typedef struct packed {
      logic                    valid;
      logic [regAddrWidth-1:0] dest;
      logic [dataWidth-1:0]    data;
   } retire_t;

endpackage

/* rtl/fetchStage.sv */
// Fetch stage holding the PC, the loadable instruction memory and the fetch/decode register
`timescale 1ns/1ps

module fetchStage (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                stall,
   input  wiscPkg::redirect_t                  redirect,
   input  logic                                halted,
   input  logic                                imemWrEn,
   input  logic [wiscPkg::imemAddrWidth-1:0]   imemWrAddr,
   input  logic [wiscPkg::dataWidth-1:0]       imemWrData,
   output wiscPkg::fetchToDecode_t             fetchOut
);
   import wiscPkg::*;

   logic [dataWidth-1:0] imem [imemDepth];
   logic [dataWidth-1:0] pc;
   instrWord_t           fetchWord;
   // Set once a HALT is fetched so nothing younger enters the pipe
   logic                 haltSeen;
   logic                 stopFetch;

   // Program load, only while the core sits in reset
   always_ff @(posedge clk) begin
      if (!rstN && imemWrEn) begin
         imem[imemWrAddr] <= imemWrData;
      end
   end

   // Asynchronous read at the current PC
   assign fetchWord = instrWord_t'(imem[pc[imemAddrWidth-1:0]]);
   assign stopFetch = haltSeen || halted;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc             <= resetPc;
         haltSeen       <= 1'b0;
         fetchOut.valid <= 1'b0;
      end else if (redirect.taken) begin
         // Redirect wins over stall and kills the word in flight
         pc             <= redirect.target;
         haltSeen       <= 1'b0;
         fetchOut.valid <= 1'b0;
      end else if (!stall) begin
         if (stopFetch) begin
            // PC frozen, bubbles only
            fetchOut.valid <= 1'b0;
         end else begin
            fetchOut.valid <= 1'b1;
            fetchOut.pc    <= pc;
            fetchOut.instr <= fetchWord;
            pc             <= pc + 1'b1;
            // A HALT in a branch shadow is cleared again by the redirect
            haltSeen       <= (fetchWord.rFmt.opcode == HALT);
         end
      end
      // Stall holds PC and the fetch/decode register
   end

endmodule

/* rtl/regFile.sv */
// Register file with eight 16-bit registers, two read ports and a write-through write port
`timescale 1ns/1ps

module regFile (
   input  logic                               clk,
   input  logic                               rstN,
   input  logic [wiscPkg::regAddrWidth-1:0]   rsAddr,
   input  logic [wiscPkg::regAddrWidth-1:0]   rtAddr,
   output logic [wiscPkg::dataWidth-1:0]      rsData,
   output logic [wiscPkg::dataWidth-1:0]      rtData,
   input  wiscPkg::retire_t                   wr
);
   import wiscPkg::*;

   localparam int numRegs = 2 ** regAddrWidth;

   logic [dataWidth-1:0] regs [numRegs];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.valid) begin
         regs[wr.dest] <= wr.data;
      end
   end

   // Same-cycle write is visible to both reads
   assign rsData = (wr.valid && (wr.dest == rsAddr)) ? wr.data : regs[rsAddr];
   assign rtData = (wr.valid && (wr.dest == rtAddr)) ? wr.data : regs[rtAddr];

endmodule

/* rtl/decodeStage.sv */
// Decode stage with control generation, register read, hazard interlock and illegal opcode trap
`timescale 1ns/1ps

module decodeStage (
   input  logic                               clk,
   input  logic                               rstN,
   input  wiscPkg::fetchToDecode_t            decIn,
   input  wiscPkg::redirect_t                 redirect,
   input  logic [wiscPkg::regAddrWidth-1:0]   exDest,
   input  logic                               exWrites,
   input  logic [wiscPkg::regAddrWidth-1:0]   memDest,
   input  logic                               memWrites,
   input  wiscPkg::retire_t                   wr,
   output logic                               stall,
   output logic                               err,
   output wiscPkg::decodeToExec_t             decOut
);
   import wiscPkg::*;

   instrWord_t              word;
   logic [dataWidth-1:0]    rsData;
   logic [dataWidth-1:0]    rtData;
   logic [dataWidth-1:0]    imm5Ext;
   logic [dataWidth-1:0]    imm8Ext;
   logic [dataWidth-1:0]    imm11Ext;
   logic                    usesRs;
   logic                    usesRt;
   logic                    illegal;
   logic                    rsHit;
   logic                    rtHit;
   decodeToExec_t           decNext;

   assign word = decIn.instr;

   // rs sits in the same bits for every format
   // rt of RTYPE shares its bits with the ST data register
   regFile regFile0 (
      .clk    (clk),
      .rstN   (rstN),
      .rsAddr (word.rFmt.rs),
      .rtAddr (word.rFmt.rt),
      .rsData (rsData),
      .rtData (rtData),
      .wr     (wr)
   );

   // Sign-extended immediates of the three widths
   assign imm5Ext  = {{(dataWidth-5){word.iFmt.imm[4]}}, word.iFmt.imm};
   assign imm8Ext  = {{(dataWidth-8){word.bFmt.imm[7]}}, word.bFmt.imm};
   assign imm11Ext = {{(dataWidth-11){word.bFmt.rs[2]}}, word.bFmt.rs, word.bFmt.imm};

   always_comb begin
      decNext        = '0;
      usesRs         = 1'b0;
      usesRt         = 1'b0;
      illegal        = 1'b0;
      decNext.valid  = decIn.valid;
      decNext.op     = word.rFmt.opcode;
      decNext.func   = word.rFmt.func;
      decNext.rsData = rsData;
      decNext.rtData = rtData;
      decNext.pc     = decIn.pc;
      case (word.rFmt.opcode)
         // No operands and no result
         NOP, HALT: ;
         ADDI, LD: begin
            usesRs            = 1'b1;
            decNext.imm       = imm5Ext;
            decNext.dest      = word.iFmt.rd;
            decNext.writesReg = 1'b1;
         end
         ST: begin
            usesRs      = 1'b1;
            usesRt      = 1'b1;
            decNext.imm = imm5Ext;
         end
         LBI: begin
            decNext.imm       = imm8Ext;
            decNext.dest      = word.bFmt.rs;
            decNext.writesReg = 1'b1;
         end
         BEQZ, BNEZ: begin
            usesRs      = 1'b1;
            decNext.imm = imm8Ext;
         end
         J: decNext.imm = imm11Ext;
         RTYPE: begin
            usesRs            = 1'b1;
            usesRt            = 1'b1;
            decNext.dest      = word.rFmt.rd;
            decNext.writesReg = 1'b1;
         end
         default: begin
            // Illegal code travels on as a nop
            illegal    = 1'b1;
            decNext.op = NOP;
         end
      endcase
   end

   // Source still owed by an older instruction in execute or memory
   assign rsHit = (exWrites && (exDest == word.rFmt.rs)) ||
                  (memWrites && (memDest == word.rFmt.rs));
   assign rtHit = (exWrites && (exDest == word.rFmt.rt)) ||
                  (memWrites && (memDest == word.rFmt.rt));
   assign stall = decIn.valid && ((usesRs && rsHit) || (usesRt && rtHit));

   always_ff @(posedge clk) begin
      if (!rstN) begin
         decOut.valid <= 1'b0;
         err          <= 1'b0;
      end else begin
         if (redirect.taken || stall) begin
            // Flushed or held, send a bubble
            decOut.valid <= 1'b0;
         end else begin
            decOut <= decNext;
         end
         // Sticky, only for an instruction that is not flushed
         if (decIn.valid && illegal && !redirect.taken) begin
            err <= 1'b1;
         end
      end
   end

endmodule

/* rtl/executeStage.sv */
// Execute stage with the ALU, branch and jump resolution, and the execute/memory register
`timescale 1ns/1ps

module executeStage (
   input  logic                               clk,
   input  logic                               rstN,
   input  wiscPkg::decodeToExec_t             exIn,
   output wiscPkg::redirect_t                 redirect,
   output logic [wiscPkg::regAddrWidth-1:0]   exDest,
   output logic                               exWrites,
   output wiscPkg::execToMem_t                exOut
);
   import wiscPkg::*;

   logic [dataWidth-1:0] aluResult;
   logic                 rsZero;
   logic                 branchTaken;
   execToMem_t           exNext;

   // ALU
   always_comb begin
      case (exIn.op)
         RTYPE: begin
            case (exIn.func)
               ADD:     aluResult = exIn.rsData + exIn.rtData;
               SUB:     aluResult = exIn.rsData - exIn.rtData;
               AND:     aluResult = exIn.rsData & exIn.rtData;
               XOR:     aluResult = exIn.rsData ^ exIn.rtData;
               default: aluResult = '0;
            endcase
         end
         // Add-immediate and load/store address
         ADDI, LD, ST: aluResult = exIn.rsData + exIn.imm;
         LBI:          aluResult = exIn.imm;
         default:      aluResult = '0;
      endcase
   end

   // Branch condition on rs
   assign rsZero = (exIn.rsData == '0);

   always_comb begin
      case (exIn.op)
         BEQZ:    branchTaken = rsZero;
         BNEZ:    branchTaken = !rsZero;
         J:       branchTaken = 1'b1;
         default: branchTaken = 1'b0;
      endcase
   end

   // One-cycle pulse while the branch sits here
   assign redirect.taken  = exIn.valid && branchTaken;
   // Target relative to the next sequential PC
   assign redirect.target = exIn.pc + 1'b1 + exIn.imm;

   // Destination seen by the decode interlock
   assign exDest   = exIn.dest;
   assign exWrites = exIn.valid && exIn.writesReg;

   always_comb begin
      exNext.valid     = exIn.valid;
      exNext.result    = aluResult;
      // Store data is the rt read
      exNext.storeData = exIn.rtData;
      exNext.memRead   = (exIn.op == LD);
      exNext.memWrite  = (exIn.op == ST);
      exNext.dest      = exIn.dest;
      exNext.writesReg = exIn.writesReg;
      exNext.halt      = (exIn.op == HALT);
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         exOut.valid <= 1'b0;
      end else begin
         exOut <= exNext;
      end
   end

endmodule

/* rtl/memoryStage.sv */
// Memory stage with data memory, writeback selection and the memory/writeback register
`timescale 1ns/1ps

module memoryStage (
   input  logic                               clk,
   input  logic                               rstN,
   input  wiscPkg::execToMem_t                memIn,
   output logic [wiscPkg::regAddrWidth-1:0]   memDest,
   output logic                               memWrites,
   output wiscPkg::retire_t                   retire,
   output logic                               halted
);
   import wiscPkg::*;

   logic [dataWidth-1:0]     dmem [dmemDepth];
   logic [dmemAddrWidth-1:0] memAddr;
   logic [dataWidth-1:0]     loadData;
   logic [dataWidth-1:0]     wbData;

   // Word address from the low result bits
   assign memAddr = memIn.result[dmemAddrWidth-1:0];

   // Data memory cleared by reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < dmemDepth; i++) begin
            dmem[i] <= '0;
         end
      end else if (memIn.valid && memIn.memWrite) begin
         dmem[memAddr] <= memIn.storeData;
      end
   end

   // Asynchronous read, a following load sees the stored word
   assign loadData = dmem[memAddr];

   // Writeback select
   assign wbData = memIn.memRead ? loadData : memIn.result;

   // Destination seen by the decode interlock
   assign memDest   = memIn.dest;
   assign memWrites = memIn.valid && memIn.writesReg;

   // Memory/writeback register, drives the register file write and the trace
   always_ff @(posedge clk) begin
      if (!rstN) begin
         retire.valid <= 1'b0;
      end else begin
         retire.valid <= memWrites;
         retire.dest  <= memIn.dest;
         retire.data  <= wbData;
      end
   end

   // Sticky until reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
      end else if (memIn.valid && memIn.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

/* rtl/wisc16Core.sv */
// Top level of the five-stage 16-bit core wiring fetch, decode, execute and memory
`timescale 1ns/1ps

module wisc16Core (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                imemWrEn,
   input  logic [wiscPkg::imemAddrWidth-1:0]   imemWrAddr,
   input  logic [wiscPkg::dataWidth-1:0]       imemWrData,
   output wiscPkg::retire_t                    retire,
   output logic                                halted,
   output logic                                err
);
   import wiscPkg::*;

   fetchToDecode_t          fetchToDecode;
   decodeToExec_t           decodeToExec;
   execToMem_t              execToMem;
   redirect_t               redirect;
   logic                    stall;
   logic [regAddrWidth-1:0] exDest;
   logic                    exWrites;
   logic [regAddrWidth-1:0] memDest;
   logic                    memWrites;

   // Fetch
   fetchStage fetch0 (
      .clk        (clk),
      .rstN       (rstN),
      .stall      (stall),
      .redirect   (redirect),
      .halted     (halted),
      .imemWrEn   (imemWrEn),
      .imemWrAddr (imemWrAddr),
      .imemWrData (imemWrData),
      .fetchOut   (fetchToDecode)
   );

   // Decode, register file written from the retire register
   decodeStage decode0 (
      .clk       (clk),
      .rstN      (rstN),
      .decIn     (fetchToDecode),
      .redirect  (redirect),
      .exDest    (exDest),
      .exWrites  (exWrites),
      .memDest   (memDest),
      .memWrites (memWrites),
      .wr        (retire),
      .stall     (stall),
      .err       (err),
      .decOut    (decodeToExec)
   );

   // Execute
   executeStage execute0 (
      .clk      (clk),
      .rstN     (rstN),
      .exIn     (decodeToExec),
      .redirect (redirect),
      .exDest   (exDest),
      .exWrites (exWrites),
      .exOut    (execToMem)
   );

   // Memory and writeback
   memoryStage memory0 (
      .clk       (clk),
      .rstN      (rstN),
      .memIn     (execToMem),
      .memDest   (memDest),
      .memWrites (memWrites),
      .retire    (retire),
      .halted    (halted)
   );

endmodule

/* verif/wisc16CoreTb.sv */
// Testbench for the five-stage 16-bit core with an in-order reference model and retire checks
`timescale 1ns/1ps

module wisc16CoreTb;
   import wiscPkg::*;

   localparam int resetCycles = 5;
   localparam int haltTimeout = 2000;
   localparam int quietCycles = 24;

   logic                     clk;
   logic                     rstN;
   logic                     imemWrEn;
   logic [imemAddrWidth-1:0] imemWrAddr;
   logic [dataWidth-1:0]     imemWrData;
   retire_t                  retire;
   logic                     halted;
   logic                     err;

   // Program image, shared by the loader and the model
   logic [dataWidth-1:0] prog [imemDepth];
   int                   progLen;
   // Expected retire trace in program order
   retire_t              expQ [$];
   retire_t              expHead;
   logic                 expAvail;
   logic                 expectErr;
   logic                 errWas;
   string                testName;
   int                   seed;
   int                   errCount;
   int                   timeoutCount;
   int                   retireCount;

   wisc16Core dut0 (
      .clk        (clk),
      .rstN       (rstN),
      .imemWrEn   (imemWrEn),
      .imemWrAddr (imemWrAddr),
      .imemWrData (imemWrData),
      .retire     (retire),
      .halted     (halted),
      .err        (err)
   );

   always #2 clk = ~clk;

   // Pop on each retire, then expose the next expected entry to the checks
   always @(posedge clk) begin
      if (rstN && retire.valid) begin
         retireCount++;
         if (expQ.size() > 0) begin
            void'(expQ.pop_front());
         end
      end
      errWas   = err;
      expAvail = (expQ.size() > 0);
      if (expAvail) begin
         expHead = expQ[0];
      end
   end

   // Checks sample at the falling edge where outputs are settled
   assert property (@(negedge clk) disable iff (!rstN)
      retire.valid |-> (expAvail && retire.dest == expHead.dest && retire.data == expHead.data))
      else begin
         errCount++;
         $display("[ERROR] %s: retire expected r%0d=%h (available %0b), actual r%0d=%h",
                  testName, expHead.dest, expHead.data, expAvail, retire.dest, retire.data);
      end

   // err never drops once raised
   assert property (@(negedge clk) disable iff (!rstN) errWas |-> err)
      else begin
         errCount++;
         $display("[ERROR] %s: err expected 1, actual %b", testName, err);
      end

   // err only for a program that runs an illegal opcode
   assert property (@(negedge clk) disable iff (!rstN) err |-> expectErr)
      else begin
         errCount++;
         $display("[ERROR] %s: err expected 0, actual %b", testName, err);
      end

   assert property (@(negedge clk) disable iff (!rstN) halted |-> !retire.valid)
      else begin
         errCount++;
         $display("[ERROR] %s: retire.valid after halt expected 0, actual 1", testName);
      end

   // Everything older than the HALT has retired once halted rises
   assert property (@(negedge clk) disable iff (!rstN) halted |-> !expAvail)
      else begin
         errCount++;
         $display("[ERROR] %s: pending retires at halt expected 0, actual %0d",
                  testName, expQ.size());
      end

   // Instruction encoders following the three formats
   function automatic logic [15:0] encR(aluFunc_t f, logic [2:0] rs, logic [2:0] rt,
                                        logic [2:0] rd);
      return {RTYPE, rs, rt, rd, f};
   endfunction

   function automatic logic [15:0] encI(opcode_t op, logic [2:0] rs, logic [2:0] rd,
                                        logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] encB(opcode_t op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] encJ(logic [10:0] off);
      return {J, off};
   endfunction

   // Opcode alone, also used for illegal codes
   function automatic logic [15:0] encOp(logic [4:0] code);
      return {code, 11'h000};
   endfunction

   // Fill unused words with NOPs that carry their own address
   task automatic startProgram(input string name);
      testName = name;
      progLen  = 0;
      for (int a = 0; a < imemDepth; a++) begin
         prog[a] = {NOP, 3'b000, 8'(a)};
      end
   endtask

   task automatic emit(input logic [15:0] w);
      prog[progLen] = w;
      progLen++;
   endtask

   // In-order reference model, one instruction per step
   task automatic runModel();
      logic [15:0] regs [8];
      logic [15:0] dmem [dmemDepth];
      logic [15:0] pc;
      logic [15:0] w;
      logic [15:0] immI;
      logic [15:0] immB;
      logic [15:0] immJ;
      logic [15:0] addr;
      logic [15:0] val;
      logic [2:0]  dst;
      logic        writes;
      logic        stop;
      int          steps;
      retire_t     ent;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < dmemDepth; i++) begin
         dmem[i] = '0;
      end
      expQ.delete();
      expectErr = 1'b0;
      pc        = resetPc;
      stop      = 1'b0;
      steps     = 0;
      while (!stop && steps < 1000) begin
         w      = prog[pc[imemAddrWidth-1:0]];
         immI   = {{11{w[4]}}, w[4:0]};
         immB   = {{8{w[7]}}, w[7:0]};
         immJ   = {{5{w[10]}}, w[10:0]};
         addr   = regs[w[10:8]] + immI;
         writes = 1'b0;
         dst    = w[7:5];
         val    = '0;
         pc     = pc + 16'd1;
         case (w[15:11])
            NOP: ;
            HALT: stop = 1'b1;
            ADDI: begin
               val    = addr;
               writes = 1'b1;
            end
            LD: begin
               val    = dmem[addr[dmemAddrWidth-1:0]];
               writes = 1'b1;
            end
            // Store data comes from the rd field
            ST: dmem[addr[dmemAddrWidth-1:0]] = regs[w[7:5]];
            LBI: begin
               val    = immB;
               dst    = w[10:8];
               writes = 1'b1;
            end
            RTYPE: begin
               case (w[1:0])
                  ADD: val = regs[w[10:8]] + regs[w[7:5]];
                  SUB: val = regs[w[10:8]] - regs[w[7:5]];
                  AND: val = regs[w[10:8]] & regs[w[7:5]];
                  XOR: val = regs[w[10:8]] ^ regs[w[7:5]];
               endcase
               dst    = w[4:2];
               writes = 1'b1;
            end
            BEQZ: if (regs[w[10:8]] == 16'd0) pc = pc + immB;
            BNEZ: if (regs[w[10:8]] != 16'd0) pc = pc + immB;
            J: pc = pc + immJ;
            // Illegal code acts as a nop and flags err
            default: expectErr = 1'b1;
         endcase
         if (writes) begin
            regs[dst] = val;
            ent.valid = 1'b1;
            ent.dest  = dst;
            ent.data  = val;
            expQ.push_back(ent);
         end
         steps++;
      end
      if (!stop) begin
         errCount++;
         $display("%s: reference model never reached HALT", testName);
      end
   endtask

   // Reset, model the program, load it, then run to halt
   task automatic runProgram();
      int cycles;
      @(posedge clk);
      #0.5;
      rstN     = 1'b0;
      imemWrEn = 1'b0;
      repeat (resetCycles) @(posedge clk);
      #0.5;
      assert (!retire.valid && !halted && !err && !dut0.stall && !dut0.redirect.taken)
         else begin
            errCount++;
            $display("[ERROR] %s: reset outputs expected 00000, actual %b%b%b%b%b", testName,
                     retire.valid, halted, err, dut0.stall, dut0.redirect.taken);
         end
      runModel();
      // Whole memory is written while the core is held in reset
      for (int a = 0; a < imemDepth; a++) begin
         imemWrEn   = 1'b1;
         imemWrAddr = imemAddrWidth'(a);
         imemWrData = prog[a];
         @(posedge clk);
         #0.5;
      end
      imemWrEn = 1'b0;
      rstN     = 1'b1;
      cycles   = 0;
      while (!halted && cycles < haltTimeout) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         timeoutCount++;
         $display("%s: timed out waiting for halted", testName);
      end
      // Watch for stray retires after the halt
      cycles = 0;
      while (cycles < quietCycles) begin
         @(negedge clk);
         cycles++;
      end
      assert (expQ.size() == 0)
         else begin
            errCount++;
            $display("[ERROR] %s: missing retires expected 0, actual %0d", testName, expQ.size());
         end
      assert (err == expectErr)
         else begin
            errCount++;
            $display("[ERROR] %s: final err expected %b, actual %b", testName, expectErr, err);
         end
   endtask

   task automatic testArith();
      logic [31:0] rnd;
      startProgram("arith");
      for (int r = 0; r < 2; r++) begin
         rnd = $random(seed);
         emit(encB(LBI, 3'd1, rnd[7:0]));
         emit(encB(LBI, 3'd2, rnd[15:8]));
         emit(encI(ADDI, 3'd1, 3'd3, rnd[20:16]));
         emit(encR(ADD, 3'd1, 3'd2, 3'd4));
         emit(encR(SUB, 3'd1, 3'd2, 3'd5));
         emit(encR(AND, 3'd3, 3'd2, 3'd6));
         emit(encR(XOR, 3'd4, 3'd5, 3'd7));
         emit(encI(ADDI, 3'd7, 3'd0, rnd[25:21]));
      end
      emit(encOp(HALT));
      runProgram();
   endtask

   // Each instruction needs the one right before it
   task automatic testDependent();
      logic [31:0] rnd;
      rnd = $random(seed);
      startProgram("dependent");
      emit(encB(LBI, 3'd1, rnd[7:0]));
      emit(encI(ADDI, 3'd1, 3'd1, rnd[12:8]));
      emit(encI(ADDI, 3'd1, 3'd2, rnd[17:13]));
      emit(encR(ADD, 3'd2, 3'd1, 3'd3));
      emit(encR(SUB, 3'd3, 3'd2, 3'd1));
      emit(encR(XOR, 3'd1, 3'd3, 3'd4));
      emit(encOp(HALT));
      runProgram();
   endtask

   task automatic testStoreLoad();
      logic [31:0] rnd;
      logic [4:0]  off;
      rnd = $random(seed);
      off = rnd[20:16];
      startProgram("storeLoad");
      emit(encB(LBI, 3'd1, rnd[7:0]));
      emit(encB(LBI, 3'd2, rnd[15:8]));
      emit(encI(ST, 3'd1, 3'd2, off));
      emit(encI(LD, 3'd1, 3'd3, off));
      emit(encI(ADDI, 3'd3, 3'd4, 5'd1));
      // Neighbouring word was never written
      emit(encI(LD, 3'd1, 3'd5, 5'(off + 5'd1)));
      emit(encOp(HALT));
      runProgram();
   endtask

   task automatic testBranches();
      logic [31:0] rnd;
      rnd = $random(seed);
      startProgram("branches");
      emit(encB(LBI, 3'd1, 8'h00));
      emit(encB(LBI, 3'd2, 8'h5a));
      emit(encB(BEQZ, 3'd1, 8'd2));
      emit(encB(LBI, 3'd6, 8'h11));
      emit(encB(LBI, 3'd6, 8'h22));
      emit(encB(LBI, 3'd3, rnd[7:0]));
      emit(encB(BNEZ, 3'd2, 8'd2));
      // Illegal word in the shadow is flushed before it can flag err
      emit(encOp(5'b11111));
      emit(encB(LBI, 3'd6, 8'h33));
      emit(encJ(11'd2));
      emit(encB(LBI, 3'd6, 8'h44));
      emit(encB(LBI, 3'd6, 8'h55));
      emit(encB(BEQZ, 3'd2, 8'd2));
      emit(encB(LBI, 3'd4, rnd[15:8]));
      emit(encB(BNEZ, 3'd1, 8'd2));
      emit(encB(LBI, 3'd5, rnd[23:16]));
      // Short countdown loop with a backward branch
      emit(encB(LBI, 3'd7, 8'd3));
      emit(encI(ADDI, 3'd7, 3'd7, 5'h1f));
      emit(encB(BNEZ, 3'd7, 8'hfe));
      emit(encOp(HALT));
      runProgram();
   endtask

   task automatic testIllegal();
      logic [31:0] rnd;
      rnd = $random(seed);
      startProgram("illegal");
      emit(encB(LBI, 3'd1, rnd[7:0]));
      emit(encOp(5'b11111));
      emit(encI(ADDI, 3'd1, 3'd2, rnd[12:8]));
      emit(encOp(5'b00010));
      emit(encR(ADD, 3'd1, 3'd2, 3'd3));
      emit(encOp(HALT));
      runProgram();
   endtask

   // Words after the HALT must never retire
   task automatic testHaltStop();
      logic [31:0] rnd;
      rnd = $random(seed);
      startProgram("haltStop");
      emit(encB(LBI, 3'd1, rnd[7:0]));
      emit(encI(ADDI, 3'd1, 3'd2, rnd[12:8]));
      emit(encOp(HALT));
      emit(encB(LBI, 3'd3, 8'h01));
      emit(encI(ADDI, 3'd3, 3'd4, 5'd2));
      emit(encB(LBI, 3'd5, 8'h7f));
      runProgram();
   endtask

   initial begin
      clk          = 1'b0;
      rstN         = 1'b0;
      imemWrEn     = 1'b0;
      imemWrAddr   = '0;
      imemWrData   = '0;
      seed         = 32'ha833;
      errCount     = 0;
      timeoutCount = 0;
      retireCount  = 0;
      expAvail     = 1'b0;
      expectErr    = 1'b0;
      errWas       = 1'b0;
      testName     = "startup";
      testArith();
      testDependent();
      testStoreLoad();
      testBranches();
      testIllegal();
      testHaltStop();
      $display("Summary: %0d retires checked, %0d errors, %0d timeouts",
               retireCount, errCount, timeoutCount);
      if (errCount == 0 && timeoutCount == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* wisc16Core.f */
rtl/wiscPkg.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/wisc16Core.sv
verif/wisc16CoreTb.sv

/* Makefile */
# Verilator simulation of the wisc16 core testbench

VERILATOR ?= verilator
TOP       ?= wisc16CoreTb
FILELIST  ?= wisc16Core.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASSTEXT  ?= TB PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
